// ==== src/bridge_pkg.sv ====
package bridge_pkg;

    // response codes as carried on bresp and rresp
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

    // owner of the shared channel
    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_IFU  = 2'd1,
        GRANT_LSU  = 2'd2
    } grant_t;

    // byte offsets inside the clint window
    localparam logic [31:0] CLINT_MTIME_LO = 32'h0000_0000;
    localparam logic [31:0] CLINT_MTIME_HI = 32'h0000_0004;

endpackage

// ==== src/axi_lite_if.sv ====
interface axi_lite_if #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
);
    logic                    awvalid;
    logic                    awready;
    logic [ADDR_WIDTH-1:0]   awaddr;

    logic                    wvalid;
    logic                    wready;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [DATA_WIDTH/8-1:0] wstrb;

    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;

    logic                    arvalid;
    logic                    arready;
    logic [ADDR_WIDTH-1:0]   araddr;

    logic                    rvalid;
    logic                    rready;
    logic [DATA_WIDTH-1:0]   rdata;
    logic [1:0]              rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );
endinterface

// ==== src/master_arbiter.sv ====
module master_arbiter #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    aclk,
    input  logic                    areset,

    input  logic                    ifu_arvalid,
    output logic                    ifu_arready,
    input  logic [ADDR_WIDTH-1:0]   ifu_araddr,
    output logic                    ifu_rvalid,
    input  logic                    ifu_rready,
    output logic [DATA_WIDTH-1:0]   ifu_rdata,
    output logic [1:0]              ifu_rresp,

    input  logic                    lsu_awvalid,
    output logic                    lsu_awready,
    input  logic [ADDR_WIDTH-1:0]   lsu_awaddr,
    input  logic                    lsu_wvalid,
    output logic                    lsu_wready,
    input  logic [DATA_WIDTH-1:0]   lsu_wdata,
    input  logic [DATA_WIDTH/8-1:0] lsu_wstrb,
    output logic                    lsu_bvalid,
    input  logic                    lsu_bready,
    output logic [1:0]              lsu_bresp,
    input  logic                    lsu_arvalid,
    output logic                    lsu_arready,
    input  logic [ADDR_WIDTH-1:0]   lsu_araddr,
    output logic                    lsu_rvalid,
    input  logic                    lsu_rready,
    output logic [DATA_WIDTH-1:0]   lsu_rdata,
    output logic [1:0]              lsu_rresp,

    axi_lite_if.master              bus
);
    bridge_pkg::grant_t grant;
    logic               last_lsu;   // lsu took the previous grant
    logic               ifu_req;
    logic               lsu_req;
    logic               done;
    logic               sel_ifu;
    logic               sel_lsu;

    assign ifu_req = ifu_arvalid;
    assign lsu_req = lsu_arvalid | lsu_awvalid;
    assign done    = (bus.rvalid & bus.rready) | (bus.bvalid & bus.bready);
    assign sel_ifu = (grant == bridge_pkg::GRANT_IFU);
    assign sel_lsu = (grant == bridge_pkg::GRANT_LSU);

    always_ff @(posedge aclk) begin
        if (areset) begin
            grant    <= bridge_pkg::GRANT_NONE;
            last_lsu <= 1'b0;
        end else if (grant == bridge_pkg::GRANT_NONE) begin
            // on a tie the master not served last wins
            if (ifu_req && (!lsu_req || last_lsu)) begin
                grant    <= bridge_pkg::GRANT_IFU;
                last_lsu <= 1'b0;
            end else if (lsu_req) begin
                grant    <= bridge_pkg::GRANT_LSU;
                last_lsu <= 1'b1;
            end
        end else if (done) begin
            grant <= bridge_pkg::GRANT_NONE;
        end
    end

    // granted master onto the shared channel
    assign bus.arvalid = sel_ifu ? ifu_arvalid : (sel_lsu & lsu_arvalid);
    assign bus.araddr  = sel_ifu ? ifu_araddr : lsu_araddr;
    assign bus.rready  = sel_ifu ? ifu_rready : (sel_lsu & lsu_rready);
    assign bus.awvalid = sel_lsu & lsu_awvalid;  // ifu never writes
    assign bus.awaddr  = lsu_awaddr;
    assign bus.wvalid  = sel_lsu & lsu_wvalid;
    assign bus.wdata   = lsu_wdata;
    assign bus.wstrb   = lsu_wstrb;
    assign bus.bready  = sel_lsu & lsu_bready;

    assign ifu_arready = sel_ifu & bus.arready;
    assign ifu_rvalid  = sel_ifu & bus.rvalid;
    assign ifu_rdata   = bus.rdata;
    assign ifu_rresp   = bus.rresp;

    assign lsu_awready = sel_lsu & bus.awready;
    assign lsu_wready  = sel_lsu & bus.wready;
    assign lsu_bvalid  = sel_lsu & bus.bvalid;
    assign lsu_bresp   = bus.bresp;
    assign lsu_arready = sel_lsu & bus.arready;
    assign lsu_rvalid  = sel_lsu & bus.rvalid;
    assign lsu_rdata   = bus.rdata;
    assign lsu_rresp   = bus.rresp;

    // a stalled response keeps its owner
    a_grant_held: assert property (@(posedge aclk) disable iff (areset)
        (bus.rvalid && !bus.rready) || (bus.bvalid && !bus.bready) |=> $stable(grant));

endmodule

// ==== src/addr_decoder.sv ====
module addr_decoder #(
    parameter int                    ADDR_WIDTH = 32,
    parameter int                    DATA_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] SOC_BASE   = '0,
    parameter logic [ADDR_WIDTH-1:0] SOC_SIZE   = '0,
    parameter logic [ADDR_WIDTH-1:0] CLINT_BASE = '0,
    parameter logic [ADDR_WIDTH-1:0] CLINT_SIZE = '0
) (
    input  logic                    aclk,
    input  logic                    areset,
    axi_lite_if.slave               up,
    axi_lite_if.master              clint,

    output logic                    soc_awvalid,
    input  logic                    soc_awready,
    output logic [ADDR_WIDTH-1:0]   soc_awaddr,
    output logic                    soc_wvalid,
    input  logic                    soc_wready,
    output logic [DATA_WIDTH-1:0]   soc_wdata,
    output logic [DATA_WIDTH/8-1:0] soc_wstrb,
    input  logic                    soc_bvalid,
    output logic                    soc_bready,
    input  logic [1:0]              soc_bresp,
    output logic                    soc_arvalid,
    input  logic                    soc_arready,
    output logic [ADDR_WIDTH-1:0]   soc_araddr,
    input  logic                    soc_rvalid,
    output logic                    soc_rready,
    input  logic [DATA_WIDTH-1:0]   soc_rdata,
    input  logic [1:0]              soc_rresp
);
    localparam logic [1:0] TGT_IDLE  = 2'd0;
    localparam logic [1:0] TGT_SOC   = 2'd1;
    localparam logic [1:0] TGT_CLINT = 2'd2;
    localparam logic [1:0] TGT_ERR   = 2'd3;

    logic [1:0]              tgt;       // held from address to response
    logic [1:0]              live;
    logic [1:0]              route;
    logic                    wr;
    logic                    w_done;
    logic                    err_valid;
    bridge_pkg::axi_resp_t   err_code;
    logic                    idle;
    logic                    wr_req;
    logic                    rd_req;
    logic                    wr_phase;
    logic [ADDR_WIDTH-1:0]   req_addr;
    logic                    in_soc;
    logic                    in_clint;
    logic                    to_soc;
    logic                    to_clint;
    logic                    to_err;
    logic                    aw_hs;
    logic                    w_hs;
    logic                    ar_hs;
    logic                    b_hs;
    logic                    r_hs;

    assign idle     = (tgt == TGT_IDLE);
    assign wr_req   = up.awvalid;
    assign rd_req   = up.arvalid & ~up.awvalid;  // writes go first
    assign req_addr = wr_req ? up.awaddr : up.araddr;
    assign in_soc   = (req_addr >= SOC_BASE) && (req_addr - SOC_BASE < SOC_SIZE);
    assign in_clint = (req_addr >= CLINT_BASE) && (req_addr - CLINT_BASE < CLINT_SIZE);

    // clint is read only so a write there is answered here
    assign live     = in_soc ? TGT_SOC : (in_clint && !wr_req) ? TGT_CLINT : TGT_ERR;
    assign route    = idle ? live : tgt;
    assign to_soc   = (route == TGT_SOC);
    assign to_clint = (route == TGT_CLINT);
    assign to_err   = (route == TGT_ERR);
    assign wr_phase = idle ? wr_req : wr;

    assign aw_hs = up.awvalid & up.awready;
    assign w_hs  = up.wvalid & up.wready;
    assign ar_hs = up.arvalid & up.arready;
    assign b_hs  = up.bvalid & up.bready;
    assign r_hs  = up.rvalid & up.rready;

    always_ff @(posedge aclk) begin
        if (areset) begin
            tgt       <= TGT_IDLE;
            wr        <= 1'b0;
            w_done    <= 1'b0;
            err_valid <= 1'b0;
        end else begin
            if (aw_hs || ar_hs) begin
                tgt <= live;
                wr  <= aw_hs;
            end else if (b_hs || r_hs) begin
                tgt <= TGT_IDLE;
            end
            if (b_hs)
                w_done <= 1'b0;
            else if (w_hs)
                w_done <= 1'b1;
            if (b_hs || r_hs)
                err_valid <= 1'b0;
            else if (to_err && (ar_hs || w_hs))
                err_valid <= 1'b1;  // local answer a cycle later
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_hs || ar_hs)
            err_code <= in_clint ? bridge_pkg::RESP_SLVERR : bridge_pkg::RESP_DECERR;
    end

    assign soc_awvalid = idle & to_soc & wr_req;
    assign soc_awaddr  = up.awaddr;
    assign soc_wvalid  = to_soc & wr_phase & ~w_done & up.wvalid;
    assign soc_wdata   = up.wdata;
    assign soc_wstrb   = up.wstrb;
    assign soc_bready  = (tgt == TGT_SOC) & wr & up.bready;
    assign soc_arvalid = idle & to_soc & rd_req;
    assign soc_araddr  = up.araddr;
    assign soc_rready  = (tgt == TGT_SOC) & ~wr & up.rready;

    assign clint.awvalid = 1'b0;
    assign clint.awaddr  = up.awaddr;
    assign clint.wvalid  = 1'b0;
    assign clint.wdata   = up.wdata;
    assign clint.wstrb   = up.wstrb;
    assign clint.bready  = 1'b0;
    assign clint.arvalid = idle & to_clint & rd_req;
    assign clint.araddr  = up.araddr;
    assign clint.rready  = (tgt == TGT_CLINT) & up.rready;

    assign up.awready = idle & wr_req & (to_soc ? soc_awready : to_err);
    assign up.wready  = wr_phase & ~w_done & (to_soc ? soc_wready : to_err);
    assign up.arready = idle & rd_req &
                        (to_soc ? soc_arready : to_clint ? clint.arready : to_err);

    assign up.bvalid = wr & ((tgt == TGT_SOC) ? soc_bvalid : err_valid);
    assign up.bresp  = (tgt == TGT_SOC) ? soc_bresp : err_code;
    assign up.rvalid = ~wr & ((tgt == TGT_SOC)   ? soc_rvalid :
                              (tgt == TGT_CLINT) ? clint.rvalid : err_valid);
    assign up.rdata  = (tgt == TGT_SOC)   ? soc_rdata :
                       (tgt == TGT_CLINT) ? clint.rdata : '0;
    assign up.rresp  = (tgt == TGT_SOC)   ? soc_rresp :
                       (tgt == TGT_CLINT) ? clint.rresp : err_code;

    // a pending clint answer blocks any soc request
    a_one_target: assert property (@(posedge aclk) disable iff (areset)
        clint.rvalid |-> !(soc_awvalid || soc_wvalid || soc_arvalid));

endmodule

// ==== src/clint_timer.sv ====
module clint_timer #(
    parameter int                    ADDR_WIDTH = 32,
    parameter int                    DATA_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] CLINT_BASE = '0
) (
    input  logic      aclk,
    input  logic      areset,
    axi_lite_if.slave bus
);
    localparam logic [ADDR_WIDTH-1:0] LO_OFF = ADDR_WIDTH'(bridge_pkg::CLINT_MTIME_LO);
    localparam logic [ADDR_WIDTH-1:0] HI_OFF = ADDR_WIDTH'(bridge_pkg::CLINT_MTIME_HI);

    logic [2*DATA_WIDTH-1:0] mtime;
    logic [DATA_WIDTH-1:0]   hi_snap;   // upper half seen by the last low read
    logic [DATA_WIDTH-1:0]   rdata_q;
    logic                    rvalid_q;
    logic [ADDR_WIDTH-1:0]   offset;
    logic                    ar_hs;

    assign offset = bus.araddr - CLINT_BASE;
    assign ar_hs  = bus.arvalid & bus.arready;

    always_ff @(posedge aclk) begin
        if (areset)
            mtime <= '0;
        else
            mtime <= mtime + 1'b1;
    end

    always_ff @(posedge aclk) begin
        if (areset) begin
            rvalid_q <= 1'b0;
            hi_snap  <= '0;
        end else begin
            if (ar_hs)
                rvalid_q <= 1'b1;
            else if (bus.rready)
                rvalid_q <= 1'b0;
            if (ar_hs && offset == LO_OFF)
                hi_snap <= mtime[2*DATA_WIDTH-1:DATA_WIDTH];
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            if (offset == LO_OFF)
                rdata_q <= mtime[DATA_WIDTH-1:0];
            else if (offset == HI_OFF)
                rdata_q <= hi_snap;
            else
                rdata_q <= '0;
        end
    end

    assign bus.arready = ~rvalid_q;
    assign bus.rvalid  = rvalid_q;
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = bridge_pkg::RESP_OKAY;

    // no write path
    assign bus.awready = 1'b0;
    assign bus.wready  = 1'b0;
    assign bus.bvalid  = 1'b0;
    assign bus.bresp   = bridge_pkg::RESP_OKAY;

endmodule

// ==== src/mem_bridge_top.sv ====
module mem_bridge_top #(
    parameter int                    ADDR_WIDTH = 32,
    parameter int                    DATA_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] SOC_BASE   = 32'h8000_0000,
    parameter logic [ADDR_WIDTH-1:0] SOC_SIZE   = 32'h1000_0000,
    parameter logic [ADDR_WIDTH-1:0] CLINT_BASE = 32'h0200_0000,
    parameter logic [ADDR_WIDTH-1:0] CLINT_SIZE = 32'h0001_0000
) (
    input  logic                    aclk,
    input  logic                    areset,

    // instruction fetch
    input  logic                    ifu_arvalid,
    output logic                    ifu_arready,
    input  logic [ADDR_WIDTH-1:0]   ifu_araddr,
    output logic                    ifu_rvalid,
    input  logic                    ifu_rready,
    output logic [DATA_WIDTH-1:0]   ifu_rdata,
    output logic [1:0]              ifu_rresp,

    // load/store
    input  logic                    lsu_awvalid,
    output logic                    lsu_awready,
    input  logic [ADDR_WIDTH-1:0]   lsu_awaddr,
    input  logic                    lsu_wvalid,
    output logic                    lsu_wready,
    input  logic [DATA_WIDTH-1:0]   lsu_wdata,
    input  logic [DATA_WIDTH/8-1:0] lsu_wstrb,
    output logic                    lsu_bvalid,
    input  logic                    lsu_bready,
    output logic [1:0]              lsu_bresp,
    input  logic                    lsu_arvalid,
    output logic                    lsu_arready,
    input  logic [ADDR_WIDTH-1:0]   lsu_araddr,
    output logic                    lsu_rvalid,
    input  logic                    lsu_rready,
    output logic [DATA_WIDTH-1:0]   lsu_rdata,
    output logic [1:0]              lsu_rresp,

    // soc memory and uart
    output logic                    soc_awvalid,
    input  logic                    soc_awready,
    output logic [ADDR_WIDTH-1:0]   soc_awaddr,
    output logic                    soc_wvalid,
    input  logic                    soc_wready,
    output logic [DATA_WIDTH-1:0]   soc_wdata,
    output logic [DATA_WIDTH/8-1:0] soc_wstrb,
    input  logic                    soc_bvalid,
    output logic                    soc_bready,
    input  logic [1:0]              soc_bresp,
    output logic                    soc_arvalid,
    input  logic                    soc_arready,
    output logic [ADDR_WIDTH-1:0]   soc_araddr,
    input  logic                    soc_rvalid,
    output logic                    soc_rready,
    input  logic [DATA_WIDTH-1:0]   soc_rdata,
    input  logic [1:0]              soc_rresp
);
    axi_lite_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) arb_bus ();
    axi_lite_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) clint_bus ();

    master_arbiter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_arbiter (
        .bus (arb_bus.master),
        .*
    );

    addr_decoder #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .SOC_BASE   (SOC_BASE),
        .SOC_SIZE   (SOC_SIZE),
        .CLINT_BASE (CLINT_BASE),
        .CLINT_SIZE (CLINT_SIZE)
    ) u_decoder (
        .up    (arb_bus.slave),
        .clint (clint_bus.master),
        .*
    );

    clint_timer #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .CLINT_BASE (CLINT_BASE)
    ) u_clint (
        .aclk   (aclk),
        .areset (areset),
        .bus    (clint_bus.slave)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic aclk,
    output logic areset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    initial begin
        areset = 1'b1;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        areset = 1'b0;
    end
endmodule

// ==== tb/tb_soc_slave.sv ====
module tb_soc_slave (
    input  logic        aclk,
    input  logic        areset,
    input  logic        soc_awvalid,
    output logic        soc_awready,
    input  logic [31:0] soc_awaddr,
    input  logic        soc_wvalid,
    output logic        soc_wready,
    input  logic [31:0] soc_wdata,
    input  logic [3:0]  soc_wstrb,
    output logic        soc_bvalid,
    input  logic        soc_bready,
    output logic [1:0]  soc_bresp,
    input  logic        soc_arvalid,
    output logic        soc_arready,
    input  logic [31:0] soc_araddr,
    output logic        soc_rvalid,
    input  logic        soc_rready,
    output logic [31:0] soc_rdata,
    output logic [1:0]  soc_rresp
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LIMIT = 200;

    logic [31:0] mem [256];
    logic [31:0] lfsr;
    logic [7:0]  idx;
    int          d;
    int          n;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two bits, one lfsr step each
    task automatic pick_delay(output int cycles);
        logic [1:0] v;
        for (int i = 0; i < 2; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        cycles = int'(v);
    endtask

    task automatic serve_read();
        pick_delay(d);
        repeat (d) @(posedge aclk);
        soc_arready <= 1'b1;
        @(posedge aclk);
        idx = soc_araddr[9:2];
        soc_arready <= 1'b0;
        pick_delay(d);
        repeat (d) @(posedge aclk);
        soc_rvalid <= 1'b1;
        soc_rdata  <= mem[idx];
        soc_rresp  <= 2'b00;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (!soc_rready && n < LIMIT);
        soc_rvalid <= 1'b0;
    endtask

    task automatic serve_write();
        pick_delay(d);
        repeat (d) @(posedge aclk);
        soc_awready <= 1'b1;
        @(posedge aclk);
        idx = soc_awaddr[9:2];
        soc_awready <= 1'b0;
        n = 0;
        while (!soc_wvalid && n < LIMIT) begin
            @(posedge aclk);
            n++;
        end
        pick_delay(d);
        repeat (d) @(posedge aclk);
        soc_wready <= 1'b1;
        @(posedge aclk);
        for (int b = 0; b < 4; b++)
            if (soc_wstrb[b]) mem[idx][8*b +: 8] = soc_wdata[8*b +: 8];
        soc_wready <= 1'b0;
        pick_delay(d);
        repeat (d) @(posedge aclk);
        soc_bvalid <= 1'b1;
        soc_bresp  <= 2'b00;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (!soc_bready && n < LIMIT);
        soc_bvalid <= 1'b0;
    endtask

    initial begin
        lfsr = 32'h41d9;
        for (int i = 0; i < 256; i++)
            mem[i] = (32'h8000_0000 + 32'(i) * 32'd4) ^ 32'h0f0f_0000;  // whole address
        soc_awready = 1'b0;
        soc_wready  = 1'b0;
        soc_bvalid  = 1'b0;
        soc_bresp   = 2'b00;
        soc_arready = 1'b0;
        soc_rvalid  = 1'b0;
        soc_rdata   = '0;
        soc_rresp   = 2'b00;
        forever begin
            @(posedge aclk);
            if (!areset) begin
                if (soc_arvalid)
                    serve_read();
                else if (soc_awvalid)
                    serve_write();
            end
        end
    end
endmodule

// ==== tb/tb_mem_bridge.sv ====
module tb_mem_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SOC_BASE   = 32'h8000_0000;
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam int          TIMEOUT    = 200;

    logic        aclk, areset;
    logic        ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    logic [31:0] ifu_araddr, ifu_rdata;
    logic [1:0]  ifu_rresp;
    logic        lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
    logic        lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic [31:0] lsu_awaddr, lsu_wdata, lsu_araddr, lsu_rdata;
    logic [3:0]  lsu_wstrb;
    logic [1:0]  lsu_bresp, lsu_rresp;
    logic        soc_awvalid, soc_awready, soc_wvalid, soc_wready, soc_bvalid, soc_bready;
    logic        soc_arvalid, soc_arready, soc_rvalid, soc_rready;
    logic [31:0] soc_awaddr, soc_wdata, soc_araddr, soc_rdata;
    logic [3:0]  soc_wstrb;
    logic [1:0]  soc_bresp, soc_rresp;

    logic [31:0] shadow [256];
    int          errors;
    int          hangs;
    bit          watch_lsu;

    tb_clock_gen   clk_gen (.*);
    mem_bridge_top uut (.*);
    tb_soc_slave   soc (.*);

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        hangs++;
        $display("timeout at %0t, no %s arrived", $time, what);
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] strb);
        logic [31:0] m;
        m = old;
        for (int b = 0; b < 4; b++)
            if (strb[b]) m[8*b +: 8] = nw[8*b +: 8];
        return m;
    endfunction

    task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        bit aw_ok;
        bit w_ok;
        bit b_ok;
        aw_ok = 0;
        w_ok  = 0;
        n     = 0;
        @(negedge aclk);
        lsu_awvalid = 1'b1;
        lsu_awaddr  = addr;
        lsu_wvalid  = 1'b1;
        lsu_wdata   = data;
        lsu_wstrb   = strb;
        lsu_bready  = 1'b1;
        while (!(aw_ok && w_ok) && n < TIMEOUT) begin
            @(posedge aclk);
            if (lsu_awready) aw_ok = 1;
            if (lsu_wready) w_ok = 1;
            @(negedge aclk);
            if (aw_ok) lsu_awvalid = 1'b0;
            if (w_ok) lsu_wvalid = 1'b0;
            n++;
        end
        n = 0;
        do begin
            @(posedge aclk);
            b_ok = lsu_bvalid;
            n++;
        end while (!b_ok && n < TIMEOUT);
        resp = lsu_bresp;
        @(negedge aclk);
        lsu_awvalid = 1'b0;
        lsu_wvalid  = 1'b0;
        lsu_bready  = 1'b0;
        if (!(aw_ok && w_ok && b_ok)) timed_out("write handshake");
    endtask

    // hold > 0 keeps lsu rready low that many cycles after rvalid
    task automatic read_word(input bit ifu, input logic [31:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp,
                             output time done_at);
        int n;
        bit ok;
        n  = 0;
        ok = 0;
        @(negedge aclk);
        if (ifu) begin
            ifu_arvalid = 1'b1;
            ifu_araddr  = addr;
            ifu_rready  = 1'b1;
        end else begin
            lsu_arvalid = 1'b1;
            lsu_araddr  = addr;
            lsu_rready  = (hold == 0);
        end
        while (!ok && n < TIMEOUT) begin
            @(posedge aclk);
            ok = ifu ? ifu_arready : lsu_arready;
            n++;
        end
        @(negedge aclk);
        if (ifu) ifu_arvalid = 1'b0;
        else lsu_arvalid = 1'b0;
        n  = 0;
        ok = 0;
        while (!ok && n < TIMEOUT) begin
            @(posedge aclk);
            ok = ifu ? ifu_rvalid : lsu_rvalid;
            n++;
        end
        data = ifu ? ifu_rdata : lsu_rdata;
        resp = ifu ? ifu_rresp : lsu_rresp;
        if (!ok) begin
            timed_out("read data");
        end else if (hold > 0) begin
            repeat (hold) begin
                @(posedge aclk);
                check(32'(lsu_rvalid), 32'd1, "rvalid under back-pressure");
                check(lsu_rdata, data, "rdata under back-pressure");
            end
            @(negedge aclk);
            lsu_rready = 1'b1;
            @(posedge aclk);
        end
        done_at = $time;
        @(negedge aclk);
        if (ifu) ifu_rready = 1'b0;
        else lsu_rready = 1'b0;
    endtask

    task automatic write_and_track(input int k, input logic [31:0] data, input logic [3:0] strb);
        logic [1:0] resp;
        lsu_write(SOC_BASE + 32'(k) * 32'd4, data, strb, resp);
        check(32'(resp), 32'(bridge_pkg::RESP_OKAY), "soc write bresp");
        shadow[k] = merge_bytes(shadow[k], data, strb);
    endtask

    task automatic read_and_compare(input bit ifu, input int k);
        logic [31:0] data;
        logic [1:0]  resp;
        time         t;
        read_word(ifu, SOC_BASE + 32'(k) * 32'd4, 0, data, resp, t);
        check(data, shadow[k], ifu ? "ifu fetch data" : "lsu read data");
        check(32'(resp), 32'(bridge_pkg::RESP_OKAY), "soc read rresp");
    endtask

    always @(posedge aclk) begin
        if (watch_lsu)
            check(32'({lsu_arready, lsu_awready, lsu_wready}), 32'd0, "lsu readies in fetch");
    end

    task automatic write_then_read_back();
        for (int k = 0; k < 6; k++)
            write_and_track(k, 32'hc0de_0000 | 32'(k * 17), 4'hf);
        write_and_track(1, 32'h1122_3344, 4'b0011);
        write_and_track(3, 32'haabb_ccdd, 4'b1000);
        write_and_track(4, 32'h5566_7788, 4'b0101);
        for (int k = 0; k < 6; k++)
            read_and_compare(1'b0, k);
    endtask

    task automatic fetch_written_words();
        watch_lsu = 1;
        for (int k = 5; k >= 0; k--)
            read_and_compare(1'b1, k);
        watch_lsu = 0;
    endtask

    task automatic race_both_masters();
        logic [31:0] d_ifu, d_lsu;
        logic [1:0]  r_ifu, r_lsu;
        time         t_ifu, t_lsu;
        // ifu was served last so the lsu wins the tie
        fork
            read_word(1'b1, SOC_BASE + 32'd8, 0, d_ifu, r_ifu, t_ifu);
            read_word(1'b0, SOC_BASE + 32'd12, 0, d_lsu, r_lsu, t_lsu);
        join
        check(d_ifu, shadow[2], "tie ifu data");
        check(d_lsu, shadow[3], "tie lsu data");
        check(32'(t_lsu < t_ifu), 32'd1, "tie order, lsu first");
    endtask

    task automatic read_mtime();
        logic [31:0] lo1, lo2, hi;
        logic [1:0]  resp;
        time         t;
        read_word(1'b0, CLINT_BASE + bridge_pkg::CLINT_MTIME_LO, 0, lo1, resp, t);
        check(32'(resp), 32'(bridge_pkg::RESP_OKAY), "mtime lo rresp");
        read_word(1'b0, CLINT_BASE + bridge_pkg::CLINT_MTIME_LO, 0, lo2, resp, t);
        read_word(1'b0, CLINT_BASE + bridge_pkg::CLINT_MTIME_HI, 0, hi, resp, t);
        check(32'(lo2 > lo1), 32'd1, "mtime advances");
        check(hi, 32'd0, "mtime hi");
    endtask

    task automatic provoke_errors();
        logic [31:0] data;
        logic [1:0]  resp;
        time         t;
        read_word(1'b0, 32'h1000_0000, 0, data, resp, t);
        check(32'(resp), 32'(bridge_pkg::RESP_DECERR), "unmapped rresp");
        check(data, 32'd0, "unmapped rdata");
        read_and_compare(1'b0, 2);
        lsu_write(CLINT_BASE, 32'hdead_beef, 4'hf, resp);
        check(32'(resp), 32'(bridge_pkg::RESP_SLVERR), "clint write bresp");
        read_and_compare(1'b0, 4);
    endtask

    task automatic stall_lsu_response();
        logic [31:0] d_ifu, d_lsu;
        logic [1:0]  r_ifu, r_lsu;
        time         t_ifu, t_lsu;
        fork
            read_word(1'b0, SOC_BASE + 32'd4, 6, d_lsu, r_lsu, t_lsu);
            begin
                repeat (3) @(negedge aclk);
                read_word(1'b1, SOC_BASE + 32'd20, 0, d_ifu, r_ifu, t_ifu);
            end
        join
        check(d_lsu, shadow[1], "stalled lsu data");
        check(d_ifu, shadow[5], "waiting ifu data");
        check(32'(t_lsu < t_ifu), 32'd1, "ifu served after stalled lsu");
    endtask

    initial begin
        int n;
        errors = 0;
        hangs = 0;
        watch_lsu = 0;
        ifu_arvalid = 1'b0;
        ifu_araddr = '0;
        ifu_rready = 1'b0;
        lsu_awvalid = 1'b0;
        lsu_awaddr = '0;
        lsu_wvalid = 1'b0;
        lsu_wdata = '0;
        lsu_wstrb = '0;
        lsu_bready = 1'b0;
        lsu_arvalid = 1'b0;
        lsu_araddr = '0;
        lsu_rready = 1'b0;
        for (int i = 0; i < 256; i++)
            shadow[i] = (32'h8000_0000 + 32'(i) * 32'd4) ^ 32'h0f0f_0000;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (areset && n < TIMEOUT);
        if (areset) timed_out("reset release");
        check(32'({ifu_arready, ifu_rvalid, lsu_awready, lsu_wready, lsu_bvalid, lsu_arready,
                   lsu_rvalid, soc_awvalid, soc_wvalid, soc_arvalid, soc_bready, soc_rready}),
              32'd0, "outputs after reset");

        write_then_read_back();
        fetch_written_words();
        race_both_masters();
        read_mtime();
        provoke_errors();
        stall_lsu_response();

        $display("errors %0d, timeouts %0d", errors, hangs);
        if (errors == 0 && hangs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end
endmodule

// ==== src.f ====
src/bridge_pkg.sv
src/axi_lite_if.sv
src/master_arbiter.sv
src/addr_decoder.sv
src/clint_timer.sv
src/mem_bridge_top.sv
tb/tb_clock_gen.sv
tb/tb_soc_slave.sv
tb/tb_mem_bridge.sv

// ==== Makefile ====
TOP := tb_mem_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o vsim
	@out=$$(./obj_dir/vsim); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
